// ==== hw/glb_settings.svh ====
`ifndef GLB_SETTINGS_SVH
`define GLB_SETTINGS_SVH

// tiles in the chain
`define GLB_NUM_TILES 4

// store headers held per tile
`define GLB_QUEUE_DEPTH 2

// configuration bus
// tile field sits in bits 10 to 7 and register field in bits 6 to 2
`define GLB_CFG_ADDR_WIDTH 11
`define GLB_CFG_DATA_WIDTH 32

// buffer word address
`define GLB_ADDR_WIDTH 12

// words per store header
`define GLB_NUM_WORDS_WIDTH 10

// stream and buffer word
`define GLB_DATA_WIDTH 16

`endif

// ==== hw/glb_pkg.sv ====
`include "glb_settings.svh"

package glb_pkg;

    // one entry of the store queue
    typedef struct packed {
        logic                            valid;
        logic [`GLB_ADDR_WIDTH-1:0]      start_addr;
        logic [`GLB_NUM_WORDS_WIDTH-1:0] num_words;
    } dma_st_header_t;

    // store engine
    typedef enum logic [1:0] {
        idle,
        wait_hdr,
        stream,
        done
    } dma_state_e;

endpackage

// ==== hw/glb_tile_cfg.sv ====
`timescale 1ns/100ps
`include "glb_settings.svh"

module glb_tile_cfg
    import glb_pkg::*;
#(
    parameter int TILE_ID = 0
) (
    input  logic                           clk,
    input  logic                           reset,

    // west side
    input  logic                           wst_wr_clk_en,
    input  logic                           wst_wr_en,
    input  logic [`GLB_CFG_ADDR_WIDTH-1:0] wst_wr_addr,
    input  logic [`GLB_CFG_DATA_WIDTH-1:0] wst_wr_data,
    input  logic                           wst_rd_clk_en,
    input  logic                           wst_rd_en,
    input  logic [`GLB_CFG_ADDR_WIDTH-1:0] wst_rd_addr,
    output logic [`GLB_CFG_DATA_WIDTH-1:0] wst_rd_data,
    output logic                           wst_rd_data_valid,

    // east side
    output logic                           est_wr_en,
    output logic [`GLB_CFG_ADDR_WIDTH-1:0] est_wr_addr,
    output logic [`GLB_CFG_DATA_WIDTH-1:0] est_wr_data,
    output logic                           est_rd_en,
    output logic [`GLB_CFG_ADDR_WIDTH-1:0] est_rd_addr,
    input  logic [`GLB_CFG_DATA_WIDTH-1:0] est_rd_data,
    input  logic                           est_rd_data_valid,

    // register outputs
    output logic                           tile_is_start,
    output logic                           tile_is_end,
    output logic                           store_dma_on,
    output logic                           store_dma_auto_on,
    output dma_st_header_t                 store_hdr [`GLB_QUEUE_DEPTH],
    input  logic [`GLB_QUEUE_DEPTH-1:0]    store_invalidate_pulse
);

    localparam logic [3:0] my_tile_id = 4'(TILE_ID);

    logic [3:0]                     wr_tile;
    logic [4:0]                     wr_reg;
    logic [3:0]                     rd_tile;
    logic [4:0]                     rd_reg;
    logic                           wr_match;
    logic                           rd_match;
    logic [`GLB_CFG_DATA_WIDTH-1:0] rd_data_int;

    assign wr_tile = wst_wr_addr[10:7];
    assign wr_reg  = wst_wr_addr[6:2];
    assign rd_tile = wst_rd_addr[10:7];
    assign rd_reg  = wst_rd_addr[6:2];

    assign wr_match = wst_wr_en && (wr_tile == my_tile_id);
    assign rd_match = wst_rd_en && (rd_tile == my_tile_id);

    // register writes
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tile_is_start     <= 1'b0;
            tile_is_end       <= 1'b0;
            store_dma_on      <= 1'b0;
            store_dma_auto_on <= 1'b0;
            for (int i = 0; i < `GLB_QUEUE_DEPTH; i++) begin
                store_hdr[i] <= '0;
            end
        end else if (wst_wr_clk_en && wr_match) begin
            case (wr_reg)
                5'd0: {tile_is_end, tile_is_start} <= wst_wr_data[1:0];
                5'd1: {store_dma_auto_on, store_dma_on} <= wst_wr_data[1:0];
                default: ;
            endcase
            // headers take two registers each from 2 upward
            for (int i = 0; i < `GLB_QUEUE_DEPTH; i++) begin
                if (wr_reg == 5'(2 + 2 * i)) begin
                    store_hdr[i].num_words <= wst_wr_data[`GLB_NUM_WORDS_WIDTH-1:0];
                end
                if (wr_reg == 5'(3 + 2 * i)) begin
                    {store_hdr[i].start_addr, store_hdr[i].valid} <=
                        wst_wr_data[`GLB_ADDR_WIDTH:0];
                end
            end
        end else begin
            // finished headers from the store engine
            for (int i = 0; i < `GLB_QUEUE_DEPTH; i++) begin
                if (store_invalidate_pulse[i]) begin
                    store_hdr[i].valid <= 1'b0;
                end
            end
        end
    end

    // read decode
    always_comb begin
        rd_data_int = '0;
        if (rd_match) begin
            case (rd_reg)
                5'd0: rd_data_int[1:0] = {tile_is_end, tile_is_start};
                5'd1: rd_data_int[1:0] = {store_dma_auto_on, store_dma_on};
                default: ;
            endcase
            for (int i = 0; i < `GLB_QUEUE_DEPTH; i++) begin
                if (rd_reg == 5'(2 + 2 * i)) begin
                    rd_data_int[`GLB_NUM_WORDS_WIDTH-1:0] = store_hdr[i].num_words;
                end
                if (rd_reg == 5'(3 + 2 * i)) begin
                    rd_data_int[`GLB_ADDR_WIDTH:0] = {store_hdr[i].start_addr,
                                                      store_hdr[i].valid};
                end
            end
        end
    end

    // forward writes east
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            est_wr_en <= 1'b0;
        end else if (wst_wr_clk_en) begin
            est_wr_en <= wst_wr_en && !wr_match;
        end
    end

    // forward reads east
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            est_rd_en <= 1'b0;
        end else if (wst_rd_clk_en) begin
            est_rd_en <= wst_rd_en && !rd_match;
        end
    end

    always_ff @(posedge clk) begin
        if (wst_wr_clk_en) begin
            est_wr_addr <= wst_wr_addr;
            est_wr_data <= wst_wr_data;
        end
        if (wst_rd_clk_en) begin
            est_rd_addr <= wst_rd_addr;
        end
    end

    // read return toward the west
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wst_rd_data       <= '0;
            wst_rd_data_valid <= 1'b0;
        end else if (wst_rd_clk_en) begin
            if (rd_match) begin
                wst_rd_data       <= rd_data_int;
                wst_rd_data_valid <= 1'b1;
            end else begin
                wst_rd_data       <= est_rd_data;
                wst_rd_data_valid <= est_rd_data_valid;
            end
        end
    end

endmodule

// ==== hw/glb_store_dma.sv ====
`timescale 1ns/100ps
`include "glb_settings.svh"

module glb_store_dma
    import glb_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        dma_on,
    input  logic                        auto_on,
    input  dma_st_header_t              hdr [`GLB_QUEUE_DEPTH],
    input  logic                        st_wr_strb,
    input  logic [`GLB_DATA_WIDTH-1:0]  st_wr_data,
    output logic [`GLB_QUEUE_DEPTH-1:0] invalidate_pulse,
    output logic                        buf_wr_en,
    output logic [`GLB_ADDR_WIDTH-1:0]  buf_wr_addr,
    output logic [`GLB_DATA_WIDTH-1:0]  buf_wr_data
);

    localparam int slot_width = (`GLB_QUEUE_DEPTH > 1) ? $clog2(`GLB_QUEUE_DEPTH) : 1;
    localparam logic [slot_width-1:0] last_slot = slot_width'(`GLB_QUEUE_DEPTH - 1);

    dma_state_e                      state;
    logic [slot_width-1:0]           slot;
    logic [slot_width-1:0]           next_slot;
    logic [`GLB_NUM_WORDS_WIDTH-1:0] word_cnt;
    dma_st_header_t                  cur_hdr;
    logic                            last_word;

    assign cur_hdr   = hdr[slot];
    assign next_slot = (slot == last_slot) ? '0 : slot + 1'b1;
    // a zero count still takes one word
    assign last_word = (word_cnt + 1'b1) >= cur_hdr.num_words;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state            <= idle;
            slot             <= '0;
            word_cnt         <= '0;
            invalidate_pulse <= '0;
            buf_wr_en        <= 1'b0;
        end else begin
            invalidate_pulse <= '0;
            buf_wr_en        <= 1'b0;
            case (state)
                idle: begin
                    if (dma_on) begin
                        state <= wait_hdr;
                    end
                end
                wait_hdr: begin
                    if (cur_hdr.valid) begin
                        state    <= stream;
                        word_cnt <= '0;
                    end
                end
                stream: begin
                    if (st_wr_strb) begin
                        buf_wr_en <= 1'b1;
                        word_cnt  <= word_cnt + 1'b1;
                        if (last_word) begin
                            invalidate_pulse[slot] <= 1'b1;
                            slot                   <= next_slot;
                            if (auto_on) begin
                                state <= wait_hdr;
                            end else begin
                                state <= done;
                            end
                        end
                    end
                end
                done: begin
                    if (!dma_on) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // buffer write payload
    always_ff @(posedge clk) begin
        if (state == stream && st_wr_strb) begin
            buf_wr_addr <= cur_hdr.start_addr + `GLB_ADDR_WIDTH'(word_cnt);
            buf_wr_data <= st_wr_data;
        end
    end

endmodule

// ==== hw/glb_tile.sv ====
`timescale 1ns/100ps
`include "glb_settings.svh"

module glb_tile
    import glb_pkg::*;
#(
    parameter int TILE_ID = 0
) (
    input  logic                           clk,
    input  logic                           reset,

    input  logic                           wst_wr_clk_en,
    input  logic                           wst_wr_en,
    input  logic [`GLB_CFG_ADDR_WIDTH-1:0] wst_wr_addr,
    input  logic [`GLB_CFG_DATA_WIDTH-1:0] wst_wr_data,
    input  logic                           wst_rd_clk_en,
    input  logic                           wst_rd_en,
    input  logic [`GLB_CFG_ADDR_WIDTH-1:0] wst_rd_addr,
    output logic [`GLB_CFG_DATA_WIDTH-1:0] wst_rd_data,
    output logic                           wst_rd_data_valid,

    output logic                           est_wr_en,
    output logic [`GLB_CFG_ADDR_WIDTH-1:0] est_wr_addr,
    output logic [`GLB_CFG_DATA_WIDTH-1:0] est_wr_data,
    output logic                           est_rd_en,
    output logic [`GLB_CFG_ADDR_WIDTH-1:0] est_rd_addr,
    input  logic [`GLB_CFG_DATA_WIDTH-1:0] est_rd_data,
    input  logic                           est_rd_data_valid,

    input  logic                           st_wr_strb,
    input  logic [`GLB_DATA_WIDTH-1:0]     st_wr_data,
    output logic                           buf_wr_en,
    output logic [`GLB_ADDR_WIDTH-1:0]     buf_wr_addr,
    output logic [`GLB_DATA_WIDTH-1:0]     buf_wr_data
);

    // start and end flags only read back over the bus for now
    logic                        tile_is_start;
    logic                        tile_is_end;
    logic                        store_dma_on;
    logic                        store_dma_auto_on;
    dma_st_header_t              store_hdr [`GLB_QUEUE_DEPTH];
    logic [`GLB_QUEUE_DEPTH-1:0] store_invalidate_pulse;

    glb_tile_cfg #(
        .TILE_ID(TILE_ID)
    ) u_cfg (
        .clk, .reset,
        .wst_wr_clk_en, .wst_wr_en, .wst_wr_addr, .wst_wr_data,
        .wst_rd_clk_en, .wst_rd_en, .wst_rd_addr, .wst_rd_data, .wst_rd_data_valid,
        .est_wr_en, .est_wr_addr, .est_wr_data, .est_rd_en, .est_rd_addr,
        .est_rd_data, .est_rd_data_valid,
        .tile_is_start, .tile_is_end, .store_dma_on, .store_dma_auto_on,
        .store_hdr, .store_invalidate_pulse
    );

    glb_store_dma u_store_dma (
        .clk, .reset,
        .dma_on           (store_dma_on),
        .auto_on          (store_dma_auto_on),
        .hdr              (store_hdr),
        .st_wr_strb, .st_wr_data,
        .invalidate_pulse (store_invalidate_pulse),
        .buf_wr_en, .buf_wr_addr, .buf_wr_data
    );

endmodule

// ==== hw/glb_top.sv ====
`timescale 1ns/100ps
`include "glb_settings.svh"

module glb_top (
    input  logic                           clk,
    input  logic                           reset,

    input  logic                           cfg_wr_clk_en,
    input  logic                           cfg_wr_en,
    input  logic [`GLB_CFG_ADDR_WIDTH-1:0] cfg_wr_addr,
    input  logic [`GLB_CFG_DATA_WIDTH-1:0] cfg_wr_data,
    input  logic                           cfg_rd_clk_en,
    input  logic                           cfg_rd_en,
    input  logic [`GLB_CFG_ADDR_WIDTH-1:0] cfg_rd_addr,
    output logic [`GLB_CFG_DATA_WIDTH-1:0] cfg_rd_data,
    output logic                           cfg_rd_data_valid,

    input  logic [`GLB_NUM_TILES-1:0]      st_wr_strb,
    input  logic [`GLB_DATA_WIDTH-1:0]     st_wr_data [`GLB_NUM_TILES],
    output logic [`GLB_NUM_TILES-1:0]      buf_wr_en,
    output logic [`GLB_ADDR_WIDTH-1:0]     buf_wr_addr [`GLB_NUM_TILES],
    output logic [`GLB_DATA_WIDTH-1:0]     buf_wr_data [`GLB_NUM_TILES]
);

    // entry k is the west side of tile k
    logic [`GLB_NUM_TILES:0]        wr_en_c;
    logic [`GLB_CFG_ADDR_WIDTH-1:0] wr_addr_c [`GLB_NUM_TILES+1];
    logic [`GLB_CFG_DATA_WIDTH-1:0] wr_data_c [`GLB_NUM_TILES+1];
    logic [`GLB_NUM_TILES:0]        rd_en_c;
    logic [`GLB_CFG_ADDR_WIDTH-1:0] rd_addr_c [`GLB_NUM_TILES+1];
    logic [`GLB_CFG_DATA_WIDTH-1:0] rd_data_c [`GLB_NUM_TILES+1];
    logic [`GLB_NUM_TILES:0]        rd_valid_c;

    assign wr_en_c[0]   = cfg_wr_en;
    assign wr_addr_c[0] = cfg_wr_addr;
    assign wr_data_c[0] = cfg_wr_data;
    assign rd_en_c[0]   = cfg_rd_en;
    assign rd_addr_c[0] = cfg_rd_addr;

    // nothing east of the last tile
    assign rd_data_c[`GLB_NUM_TILES]  = '0;
    assign rd_valid_c[`GLB_NUM_TILES] = 1'b0;

    for (genvar i = 0; i < `GLB_NUM_TILES; i++) begin : g_tile
        glb_tile #(
            .TILE_ID(i)
        ) u_tile (
            .clk, .reset,
            .wst_wr_clk_en     (cfg_wr_clk_en),
            .wst_wr_en         (wr_en_c[i]),
            .wst_wr_addr       (wr_addr_c[i]),
            .wst_wr_data       (wr_data_c[i]),
            .wst_rd_clk_en     (cfg_rd_clk_en),
            .wst_rd_en         (rd_en_c[i]),
            .wst_rd_addr       (rd_addr_c[i]),
            .wst_rd_data       (rd_data_c[i]),
            .wst_rd_data_valid (rd_valid_c[i]),
            .est_wr_en         (wr_en_c[i+1]),
            .est_wr_addr       (wr_addr_c[i+1]),
            .est_wr_data       (wr_data_c[i+1]),
            .est_rd_en         (rd_en_c[i+1]),
            .est_rd_addr       (rd_addr_c[i+1]),
            .est_rd_data       (rd_data_c[i+1]),
            .est_rd_data_valid (rd_valid_c[i+1]),
            .st_wr_strb        (st_wr_strb[i]),
            .st_wr_data        (st_wr_data[i]),
            .buf_wr_en         (buf_wr_en[i]),
            .buf_wr_addr       (buf_wr_addr[i]),
            .buf_wr_data       (buf_wr_data[i])
        );
    end

    // output stage on the read return
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cfg_rd_data       <= '0;
            cfg_rd_data_valid <= 1'b0;
        end else if (cfg_rd_clk_en) begin
            cfg_rd_data       <= rd_data_c[0];
            cfg_rd_data_valid <= rd_valid_c[0];
        end
    end

endmodule

// ==== bench/glb_tb.sv ====
`timescale 1ns/100ps
`include "glb_settings.svh"

module glb_tb
    import glb_pkg::*;
();

    typedef struct packed {
        logic [3:0]                 tile;
        logic [`GLB_ADDR_WIDTH-1:0] addr;
        logic [`GLB_DATA_WIDTH-1:0] data;
    } buf_write_t;

    logic                           clk;
    logic                           reset;
    logic                           cfg_wr_clk_en;
    logic                           cfg_wr_en;
    logic [`GLB_CFG_ADDR_WIDTH-1:0] cfg_wr_addr;
    logic [`GLB_CFG_DATA_WIDTH-1:0] cfg_wr_data;
    logic                           cfg_rd_clk_en;
    logic                           cfg_rd_en;
    logic [`GLB_CFG_ADDR_WIDTH-1:0] cfg_rd_addr;
    logic [`GLB_CFG_DATA_WIDTH-1:0] cfg_rd_data;
    logic                           cfg_rd_data_valid;
    logic [`GLB_NUM_TILES-1:0]      st_wr_strb;
    logic [`GLB_DATA_WIDTH-1:0]     st_wr_data [`GLB_NUM_TILES];
    logic [`GLB_NUM_TILES-1:0]      buf_wr_en;
    logic [`GLB_ADDR_WIDTH-1:0]     buf_wr_addr [`GLB_NUM_TILES];
    logic [`GLB_DATA_WIDTH-1:0]     buf_wr_data [`GLB_NUM_TILES];

    logic [15:0] lfsr_state;
    logic        rd_pending;
    buf_write_t  exp_q [$];

    // reference model, one entry per tile
    logic           m_on   [`GLB_NUM_TILES];
    logic           m_auto [`GLB_NUM_TILES];
    int             m_slot [`GLB_NUM_TILES];
    int             m_cnt  [`GLB_NUM_TILES];
    dma_state_e     m_st   [`GLB_NUM_TILES];
    dma_st_header_t m_hdr  [`GLB_NUM_TILES][`GLB_QUEUE_DEPTH];

    glb_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_cfg_data(input logic [`GLB_CFG_DATA_WIDTH-1:0] got,
                                  input logic [`GLB_CFG_DATA_WIDTH-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("ERR cfg_rd_data got %h expected %h", got, exp));
        end
    endtask

    task automatic check_buf_write(input int t,
                                   input logic [`GLB_ADDR_WIDTH-1:0] got_addr,
                                   input logic [`GLB_ADDR_WIDTH-1:0] exp_addr,
                                   input logic [`GLB_DATA_WIDTH-1:0] got_data,
                                   input logic [`GLB_DATA_WIDTH-1:0] exp_data);
        if (got_addr !== exp_addr) begin
            report_failure($sformatf("ERR buf_wr_addr[%0d] got %h expected %h",
                                     t, got_addr, exp_addr));
        end
        if (got_data !== exp_data) begin
            report_failure($sformatf("ERR buf_wr_data[%0d] got %h expected %h",
                                     t, got_data, exp_data));
        end
    endtask

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hb400;
        end
        return s >> 1;
    endfunction

    // implemented bits of each register in the map
    function automatic logic [31:0] field_mask(input int r);
        case (r)
            0, 1:    return 32'h0000_0003;
            2, 4:    return 32'h0000_03ff;
            3, 5:    return 32'h0000_1fff;
            default: return 32'h0000_0000;
        endcase
    endfunction

    task automatic model_write(input int t, input int r, input logic [31:0] data);
        if (r == 1) begin
            m_on[t]   = data[0];
            m_auto[t] = data[1];
        end
        for (int i = 0; i < `GLB_QUEUE_DEPTH; i++) begin
            if (r == 2 + 2 * i) begin
                m_hdr[t][i].num_words = data[`GLB_NUM_WORDS_WIDTH-1:0];
            end
            if (r == 3 + 2 * i) begin
                {m_hdr[t][i].start_addr, m_hdr[t][i].valid} = data[`GLB_ADDR_WIDTH:0];
            end
        end
    endtask

    // one clock of the store engine
    task automatic model_step(input int t, input logic strb,
                              input logic [`GLB_DATA_WIDTH-1:0] word);
        buf_write_t e;
        case (m_st[t])
            idle: begin
                if (m_on[t]) begin
                    m_st[t] = wait_hdr;
                end
            end
            wait_hdr: begin
                if (m_hdr[t][m_slot[t]].valid) begin
                    m_st[t]  = stream;
                    m_cnt[t] = 0;
                end
            end
            stream: begin
                if (strb) begin
                    e.tile = 4'(t);
                    e.addr = m_hdr[t][m_slot[t]].start_addr + `GLB_ADDR_WIDTH'(m_cnt[t]);
                    e.data = word;
                    exp_q.push_back(e);
                    m_cnt[t]++;
                    if (m_cnt[t] >= m_hdr[t][m_slot[t]].num_words) begin
                        m_hdr[t][m_slot[t]].valid = 1'b0;
                        m_slot[t] = (m_slot[t] + 1) % `GLB_QUEUE_DEPTH;
                        m_st[t]   = m_auto[t] ? wait_hdr : done;
                    end
                end
            end
            default: begin
                if (!m_on[t]) begin
                    m_st[t] = idle;
                end
            end
        endcase
    endtask

    task automatic cfg_write(input int t, input int r, input logic [31:0] data);
        @(posedge clk);
        cfg_wr_en   <= 1'b1;
        cfg_wr_addr <= {4'(t), 5'(r), 2'b00};
        cfg_wr_data <= data;
        @(posedge clk);
        cfg_wr_en <= 1'b0;
        // tile t takes the write t+1 cycles after the strobe
        repeat (t + 2) @(posedge clk);
        model_write(t, r, data);
        repeat (3) model_step(t, 1'b0, '0);
    endtask

    task automatic cfg_read(input int t, input int r, input logic [31:0] exp);
        int wait_cnt;
        @(posedge clk);
        rd_pending  = 1'b1;
        cfg_rd_en   <= 1'b1;
        cfg_rd_addr <= {4'(t), 5'(r), 2'b00};
        @(posedge clk);
        cfg_rd_en <= 1'b0;
        wait_cnt = 0;
        do begin
            @(negedge clk);
            wait_cnt++;
        end while (!cfg_rd_data_valid && wait_cnt < 40);
        if (!cfg_rd_data_valid) begin
            report_failure("timeout: read data valid never came back");
        end
        check_cfg_data(cfg_rd_data, exp);
        @(posedge clk);
        rd_pending = 1'b0;
    endtask

    // every register of every tile, written with ones and cleared again
    task automatic sweep_registers();
        logic [31:0] pattern;
        for (int t = 0; t < `GLB_NUM_TILES; t++) begin
            for (int r = 0; r < 8; r++) begin
                // keep dma_on and header valid low so no engine starts
                pattern = (r == 1 || r == 3 || r == 5) ? 32'hffff_fffe : 32'hffff_ffff;
                cfg_write(t, r, pattern);
                cfg_read(t, r, pattern & field_mask(r));
                for (int u = 0; u < `GLB_NUM_TILES; u++) begin
                    if (u != t) begin
                        cfg_read(u, r, '0);
                    end
                end
                cfg_write(t, r, '0);
                cfg_read(t, r, '0);
            end
        end
    endtask

    task automatic stream_burst(input int t, input int n);
        logic [`GLB_DATA_WIDTH-1:0] word;
        int wait_cnt;
        repeat (3) begin
            @(posedge clk);
            model_step(t, 1'b0, '0);
        end
        for (int i = 0; i < n; i++) begin
            for (int b = 0; b < `GLB_DATA_WIDTH; b++) begin
                word       = {word[`GLB_DATA_WIDTH-2:0], lfsr_state[0]};
                lfsr_state = lfsr_step(lfsr_state);
            end
            @(posedge clk);
            st_wr_strb[t] <= 1'b1;
            st_wr_data[t] <= word;
            model_step(t, 1'b1, word);
        end
        @(posedge clk);
        st_wr_strb[t] <= 1'b0;
        wait_cnt = 0;
        while (exp_q.size() != 0 && wait_cnt < 20) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (exp_q.size() != 0) begin
            report_failure("timeout: expected buffer writes did not all appear");
        end
    endtask

    // buffer writes and stray read responses
    always @(negedge clk) begin
        buf_write_t e;
        if (!reset) begin
            if (cfg_rd_data_valid && !rd_pending) begin
                report_failure("read data valid appeared without a read request");
            end
            for (int t = 0; t < `GLB_NUM_TILES; t++) begin
                if (buf_wr_en[t]) begin
                    if (exp_q.size() == 0 || exp_q[0].tile != t) begin
                        report_failure($sformatf("unexpected buffer write on tile %0d", t));
                    end else begin
                        e = exp_q.pop_front();
                        check_buf_write(t, buf_wr_addr[t], e.addr, buf_wr_data[t], e.data);
                    end
                end
            end
        end
    end

    initial begin
        int          fd;
        int          t;
        int          r;
        logic [31:0] v;
        byte         op;
        string       line;
        reset         = 1'b1;
        cfg_wr_clk_en = 1'b1;
        cfg_wr_en     = 1'b0;
        cfg_wr_addr   = '0;
        cfg_wr_data   = '0;
        cfg_rd_clk_en = 1'b1;
        cfg_rd_en     = 1'b0;
        cfg_rd_addr   = '0;
        st_wr_strb    = '0;
        rd_pending    = 1'b0;
        lfsr_state    = 16'd17043;
        for (int i = 0; i < `GLB_NUM_TILES; i++) begin
            st_wr_data[i] = '0;
            m_on[i]       = 1'b0;
            m_auto[i]     = 1'b0;
            m_slot[i]     = 0;
            m_cnt[i]      = 0;
            m_st[i]       = idle;
            for (int j = 0; j < `GLB_QUEUE_DEPTH; j++) begin
                m_hdr[i][j] = '0;
            end
        end
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        // everything reads zero out of reset, mapped or not
        for (int i = 0; i < `GLB_NUM_TILES; i++) begin
            for (int j = 0; j < 8; j++) begin
                cfg_read(i, j, '0);
            end
        end

        sweep_registers();

        fd = $fopen("bench/glb_cases.txt", "r");
        if (fd == 0) begin
            report_failure("could not open bench/glb_cases.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.substr(0, 0) != "#") begin
                v = '0;
                void'($sscanf(line, "%c %d %d %h", op, t, r, v));
                if (op == "W") begin
                    cfg_write(t, r, v);
                end else if (op == "R") begin
                    cfg_read(t, r, v);
                end else if (op == "S") begin
                    stream_burst(t, r);
                end else begin
                    report_failure($sformatf("unknown command in case file: %s", line));
                end
            end
        end
        $fclose(fd);

        repeat (5) @(posedge clk);
        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== bench/glb_cases.txt ====
# W tile reg data_hex = config write ; R tile reg expected_hex = read and compare
# S tile words = burst of LFSR stream words into that tile
W 0 0 ffffffff
R 0 0 00000003
R 1 0 00000000
R 3 0 00000000
W 1 1 fffffffe
R 1 1 00000002
R 0 1 00000000
R 2 1 00000000
W 2 2 0000f3ff
R 2 2 000003ff
R 3 2 00000000
W 3 3 fffff557
R 3 3 00001557
R 2 3 00000000
W 3 4 00000abc
R 3 4 000002bc
W 3 5 ffff2abc
R 3 5 00000abc
W 2 6 ffffffff
R 2 6 00000000
R 0 7 00000000
# single header on tile 0, no auto
W 0 2 00000005
W 0 3 00000201
W 0 1 00000001
S 0 5
R 0 3 00000200
# second header stays untouched while the engine is done
W 0 4 00000003
W 0 5 00000401
S 0 3
R 0 5 00000401
# auto mode walks both headers of tile 1
W 1 2 00000004
W 1 3 00000021
W 1 4 00000003
W 1 5 00000801
W 1 1 00000003
S 1 4
S 1 3
R 1 3 00000020
R 1 5 00000800

// ==== verilog.f ====
+incdir+hw
hw/glb_pkg.sv
hw/glb_tile_cfg.sv
hw/glb_store_dma.sv
hw/glb_tile.sv
hw/glb_top.sv
bench/glb_tb.sv
